// ==== rtl/riscvPkg.sv ====
`default_nettype none

package riscvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // instruction class handed from decode to the ALU
    typedef logic [2:0] aluOp_t;

    // kind of control transfer resolved in EXE
    typedef logic [1:0] branch_t;

    // RV32I major opcodes
    localparam logic [6:0] opcOp = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLoad = 7'b0000011;
    localparam logic [6:0] opcStore = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal = 7'b1101111;
    localparam logic [6:0] opcJalr = 7'b1100111;
    localparam logic [6:0] opcLui = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;

    // aluNone must stay zero so that a bubble does nothing
    localparam aluOp_t aluNone = 3'd0;
    localparam aluOp_t aluReg = 3'd1;
    localparam aluOp_t aluImm = 3'd2;
    localparam aluOp_t aluMem = 3'd3;
    localparam aluOp_t aluBranch = 3'd4;
    localparam aluOp_t aluUpper = 3'd5;

    localparam branch_t brNone = 2'd0;
    localparam branch_t brCond = 2'd1;
    localparam branch_t brJal = 2'd2;
    localparam branch_t brJalr = 2'd3;

    // funct3 encodings of the conditional branches
    localparam funct3_t f3Beq = 3'b000;
    localparam funct3_t f3Bne = 3'b001;
    localparam funct3_t f3Blt = 3'b100;
    localparam funct3_t f3Bge = 3'b101;
    localparam funct3_t f3Bltu = 3'b110;
    localparam funct3_t f3Bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== rtl/idExeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// one decoded instruction as it moves from ID into EXE
interface idExeIf import riscvPkg::*; ();

    word_t pc;
    word_t rs1Data;
    word_t rs2Data;
    word_t imm;
    regAddr_t rd;
    regAddr_t rs1;
    regAddr_t rs2;
    funct3_t funct3;
    funct7_t funct7;
    aluOp_t aluOp;
    logic aluSrc;
    logic pcToRegSrc;
    logic rdSrc;
    logic memToReg;
    logic memWrite;
    logic memRead;
    logic regWrite;
    branch_t branch;

    modport producer (
        output pc, rs1Data, rs2Data, imm, rd, rs1, rs2, funct3, funct7,
        output aluOp, aluSrc, pcToRegSrc, rdSrc, memToReg, memWrite, memRead, regWrite, branch
    );

    modport consumer (
        input pc, rs1Data, rs2Data, imm, rd, rs1, rs2, funct3, funct7,
        input aluOp, aluSrc, pcToRegSrc, rdSrc, memToReg, memWrite, memRead, regWrite, branch
    );

endinterface

`default_nettype wire

// ==== rtl/controlDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import riscvPkg::*; (
    input word_t instr,
    input word_t pc,
    input logic flushIn,
    input logic branchTaken,
    output logic flush,
    idExeIf.producer idBus
);

    logic writesRd;

    // a taken transfer in EXE means the instruction now in ID is wrong-path
    assign flush = flushIn | branchTaken;

    assign idBus.pc = pc;
    assign idBus.rs1 = instr[19:15];
    assign idBus.rs2 = instr[24:20];
    assign idBus.funct3 = instr[14:12];
    assign idBus.funct7 = instr[31:25];

    // stores and branches carry immediate bits in the rd field
    assign idBus.rd = writesRd ? instr[11:7] : '0;
    assign idBus.regWrite = writesRd && (instr[11:7] != '0);

    always_comb begin
        idBus.aluOp = aluNone;
        idBus.aluSrc = 1'b0;
        idBus.pcToRegSrc = 1'b0;
        idBus.rdSrc = 1'b0;
        idBus.memToReg = 1'b0;
        idBus.memWrite = 1'b0;
        idBus.memRead = 1'b0;
        idBus.branch = brNone;
        writesRd = 1'b0;
        unique case (instr[6:0])
            opcOp: begin
                idBus.aluOp = aluReg;
                writesRd = 1'b1;
            end
            opcOpImm: begin
                idBus.aluOp = aluImm;
                idBus.aluSrc = 1'b1;
                writesRd = 1'b1;
            end
            opcLoad: begin
                idBus.aluOp = aluMem;
                idBus.aluSrc = 1'b1;
                idBus.memRead = 1'b1;
                idBus.memToReg = 1'b1;
                writesRd = 1'b1;
            end
            opcStore: begin
                idBus.aluOp = aluMem;
                idBus.aluSrc = 1'b1;
                idBus.memWrite = 1'b1;
            end
            opcBranch: begin
                idBus.aluOp = aluBranch;
                idBus.branch = brCond;
            end
            opcJal, opcJalr: begin
                idBus.rdSrc = 1'b1;
                idBus.pcToRegSrc = 1'b1;
                idBus.branch = (instr[6:0] == opcJal) ? brJal : brJalr;
                writesRd = 1'b1;
            end
            opcLui: begin
                idBus.aluOp = aluUpper;
                idBus.aluSrc = 1'b1;
                writesRd = 1'b1;
            end
            opcAuipc: begin
                idBus.rdSrc = 1'b1;
                writesRd = 1'b1;
            end
            // anything else leaves every control level low
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile import riscvPkg::*; (
    input logic clk,
    input logic reset,
    input regAddr_t rs1,
    input regAddr_t rs2,
    input logic wbRegWrite,
    input regAddr_t wbRd,
    input word_t wbData,
    output word_t rs1Data,
    output word_t rs2Data
);

    // x0 has no storage
    word_t regs [1:31];

    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wbRegWrite && (wbRd == addr)) begin
            // same-cycle write-back is seen by the reader
            value = wbData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // the read ports follow the array and the write-back port as well as the addresses
    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && (wbRd != '0)) begin
            regs[wbRd] <= wbData;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/immediateGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module immediateGen import riscvPkg::*; (
    input word_t instr,
    output word_t imm
);

    word_t immI;
    word_t immS;
    word_t immB;
    word_t immU;
    word_t immJ;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        unique case (instr[6:0])
            opcOpImm, opcLoad, opcJalr: imm = immI;
            opcStore: imm = immS;
            opcBranch: imm = immB;
            opcLui, opcAuipc: imm = immU;
            opcJal: imm = immJ;
            // register-register ops have no immediate
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/idExeReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module idExeReg import riscvPkg::*; (
    input logic clk,
    input logic reset,
    input logic flush,
    idExeIf.consumer idBus,
    idExeIf.producer exeBus
);

    // a flush loads the all-zero bubble, same as reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exeBus.pc <= '0;
            exeBus.rs1Data <= '0;
            exeBus.rs2Data <= '0;
            exeBus.imm <= '0;
            exeBus.rd <= '0;
            exeBus.rs1 <= '0;
            exeBus.rs2 <= '0;
            exeBus.funct3 <= '0;
            exeBus.funct7 <= '0;
            exeBus.aluOp <= aluNone;
            exeBus.aluSrc <= 1'b0;
            exeBus.pcToRegSrc <= 1'b0;
            exeBus.rdSrc <= 1'b0;
            exeBus.memToReg <= 1'b0;
            exeBus.memWrite <= 1'b0;
            exeBus.memRead <= 1'b0;
            exeBus.regWrite <= 1'b0;
            exeBus.branch <= brNone;
        end else if (flush) begin
            exeBus.pc <= '0;
            exeBus.rs1Data <= '0;
            exeBus.rs2Data <= '0;
            exeBus.imm <= '0;
            exeBus.rd <= '0;
            exeBus.rs1 <= '0;
            exeBus.rs2 <= '0;
            exeBus.funct3 <= '0;
            exeBus.funct7 <= '0;
            exeBus.aluOp <= aluNone;
            exeBus.aluSrc <= 1'b0;
            exeBus.pcToRegSrc <= 1'b0;
            exeBus.rdSrc <= 1'b0;
            exeBus.memToReg <= 1'b0;
            exeBus.memWrite <= 1'b0;
            exeBus.memRead <= 1'b0;
            exeBus.regWrite <= 1'b0;
            exeBus.branch <= brNone;
        end else begin
            exeBus.pc <= idBus.pc;
            exeBus.rs1Data <= idBus.rs1Data;
            exeBus.rs2Data <= idBus.rs2Data;
            exeBus.imm <= idBus.imm;
            exeBus.rd <= idBus.rd;
            exeBus.rs1 <= idBus.rs1;
            exeBus.rs2 <= idBus.rs2;
            exeBus.funct3 <= idBus.funct3;
            exeBus.funct7 <= idBus.funct7;
            exeBus.aluOp <= idBus.aluOp;
            exeBus.aluSrc <= idBus.aluSrc;
            exeBus.pcToRegSrc <= idBus.pcToRegSrc;
            exeBus.rdSrc <= idBus.rdSrc;
            exeBus.memToReg <= idBus.memToReg;
            exeBus.memWrite <= idBus.memWrite;
            exeBus.memRead <= idBus.memRead;
            exeBus.regWrite <= idBus.regWrite;
            exeBus.branch <= idBus.branch;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeStage import riscvPkg::*; (
    idExeIf.consumer exeBus,
    output word_t result,
    output word_t storeData,
    output logic branchTaken,
    output word_t branchTarget
);

    word_t opA;
    word_t opB;
    word_t aluResult;
    logic altOp;
    logic condTrue;

    assign opA = exeBus.rs1Data;
    assign opB = exeBus.aluSrc ? exeBus.imm : exeBus.rs2Data;

    // funct7 bit 5 picks sub and sra, but addi has no sub form
    assign altOp = exeBus.funct7[5];

    always_comb begin
        aluResult = '0;
        case (exeBus.aluOp)
            aluReg, aluImm: begin
                unique case (exeBus.funct3)
                    3'b000: aluResult = (exeBus.aluOp == aluReg && altOp) ? opA - opB : opA + opB;
                    3'b001: aluResult = opA << opB[4:0];
                    3'b010: aluResult = word_t'($signed(opA) < $signed(opB));
                    3'b011: aluResult = word_t'(opA < opB);
                    3'b100: aluResult = opA ^ opB;
                    3'b101: aluResult = altOp ? word_t'($signed(opA) >>> opB[4:0]) : opA >> opB[4:0];
                    3'b110: aluResult = opA | opB;
                    3'b111: aluResult = opA & opB;
                    default: aluResult = '0;
                endcase
            end
            aluMem: aluResult = opA + opB;
            // lui is zero plus the upper immediate
            aluUpper: aluResult = '0 + opB;
            default: aluResult = '0;
        endcase
    end

    always_comb begin
        unique case (exeBus.funct3)
            f3Beq: condTrue = (opA == exeBus.rs2Data);
            f3Bne: condTrue = (opA != exeBus.rs2Data);
            f3Blt: condTrue = ($signed(opA) < $signed(exeBus.rs2Data));
            f3Bge: condTrue = ($signed(opA) >= $signed(exeBus.rs2Data));
            f3Bltu: condTrue = (opA < exeBus.rs2Data);
            f3Bgeu: condTrue = (opA >= exeBus.rs2Data);
            default: condTrue = 1'b0;
        endcase
    end

    always_comb begin
        unique case (exeBus.branch)
            brCond: branchTaken = condTrue;
            brJal, brJalr: branchTaken = 1'b1;
            default: branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = (exeBus.branch == brJalr) ? ((opA + exeBus.imm) & ~word_t'(1))
                                                    : exeBus.pc + exeBus.imm;

    // link address for jal and jalr, pc-relative value for auipc
    assign result = !exeBus.rdSrc ? aluResult
                  : exeBus.pcToRegSrc ? exeBus.pc + word_t'(4) : exeBus.pc + exeBus.imm;

    assign storeData = exeBus.rs2Data;

endmodule

`default_nettype wire

// ==== rtl/decodeExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeExecute import riscvPkg::*; (
    input logic clk,
    input logic reset,
    input word_t instr,
    input word_t pc,
    input logic flushIn,
    input logic wbRegWrite,
    input regAddr_t wbRd,
    input word_t wbData,
    output word_t result,
    output word_t storeData,
    output regAddr_t exeRd,
    output logic exeRegWrite,
    output logic exeMemWrite,
    output logic exeMemRead,
    output logic exeMemToReg,
    output logic branchTaken,
    output word_t branchTarget
);

    logic flush;

    idExeIf idBus ();
    idExeIf exeBus ();

    controlDecoder decoder (
        .instr(instr),
        .pc(pc),
        .flushIn(flushIn),
        .branchTaken(branchTaken),
        .flush(flush),
        .idBus(idBus)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .rs1(idBus.rs1),
        .rs2(idBus.rs2),
        .wbRegWrite(wbRegWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .rs1Data(idBus.rs1Data),
        .rs2Data(idBus.rs2Data)
    );

    immediateGen immGen (
        .instr(instr),
        .imm(idBus.imm)
    );

    idExeReg pipeReg (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .idBus(idBus),
        .exeBus(exeBus)
    );

    executeStage execute (
        .exeBus(exeBus),
        .result(result),
        .storeData(storeData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    assign exeRd = exeBus.rd;
    assign exeRegWrite = exeBus.regWrite;
    assign exeMemWrite = exeBus.memWrite;
    assign exeMemRead = exeBus.memRead;
    assign exeMemToReg = exeBus.memToReg;

endmodule

`default_nettype wire

// ==== testbench/decodeExecute_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeExecuteAssertions import riscvPkg::*; (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic regWrite,
    input logic memWrite,
    input logic memRead,
    input branch_t branch,
    input logic branchTaken
);

    // number of assertion failures seen so far
    int failures = 0;

    // a bubble loaded by reset or flush must not write anything
    property bubbleIsQuiet;
        @(posedge clk) (reset || flush) |=> !(regWrite || memWrite || memRead);
    endproperty

    property takenNeedsBranch;
        @(posedge clk) disable iff (reset) (branch == brNone) |-> !branchTaken;
    endproperty

    property singleMemoryAccess;
        @(posedge clk) disable iff (reset) !(memWrite && memRead);
    endproperty

    bubbleQuiet: assert property (bubbleIsQuiet)
        else begin
            $error("control levels active in EXE after a flush or reset");
            failures++;
        end

    noBranchNoTransfer: assert property (takenNeedsBranch)
        else begin
            $error("branchTaken high while EXE holds no branch");
            failures++;
        end

    oneAccess: assert property (singleMemoryAccess)
        else begin
            $error("load and store raised together in EXE");
            failures++;
        end

endmodule

`default_nettype wire

// ==== testbench/decodeExecuteTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeExecuteTb import riscvPkg::*; ();

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic flushIn;
        logic wbEn;
        regAddr_t wbRd;
        word_t wbData;
        word_t result;
        regAddr_t rd;
        logic regWrite;
        logic memWrite;
        logic memRead;
        logic taken;
        word_t target;
        logic checkTarget;
        word_t storeData;
        logic checkStore;
    } tableRow_t;

    logic clk;
    logic reset;
    word_t instr;
    word_t pc;
    logic flushIn;
    logic wbRegWrite;
    regAddr_t wbRd;
    word_t wbData;
    word_t result;
    word_t storeData;
    regAddr_t exeRd;
    logic exeRegWrite;
    logic exeMemWrite;
    logic exeMemRead;
    logic exeMemToReg;
    logic branchTaken;
    word_t branchTarget;

    tableRow_t rows[$];
    string rowNames[$];
    int errorCount = 0;
    int rowErrors = 0;
    int failedRows = 0;
    int checkedRows = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    // x1..x8 hold a mix of small, negative and sign-bit values
    word_t preloadValue [1:8] = '{32'h0000_0010, 32'h0000_0003, 32'hFFFF_FFF0, 32'h8000_0000,
                                  32'h1234_5678, 32'h0000_0010, 32'h0000_1000, 32'hDEAD_BEEF};

    decodeExecute uut (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .flushIn(flushIn),
        .wbRegWrite(wbRegWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .result(result),
        .storeData(storeData),
        .exeRd(exeRd),
        .exeRegWrite(exeRegWrite),
        .exeMemWrite(exeMemWrite),
        .exeMemRead(exeMemRead),
        .exeMemToReg(exeMemToReg),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    bind decodeExecute decodeExecuteAssertions checks (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .regWrite(exeBus.regWrite),
        .memWrite(exeBus.memWrite),
        .memRead(exeBus.memRead),
        .branch(exeBus.branch),
        .branchTaken(branchTaken)
    );

    // RV32I instruction formats
    function automatic word_t encR(input logic [6:0] f7, input regAddr_t rs2, input regAddr_t rs1,
                                   input logic [2:0] f3, input regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encI(input int imm, input regAddr_t rs1, input logic [2:0] f3,
                                   input regAddr_t rd, input logic [6:0] opcode);
        return {imm[11:0], rs1, f3, rd, opcode};
    endfunction

    function automatic word_t encS(input int imm, input regAddr_t rs2, input regAddr_t rs1,
                                   input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encB(input int imm, input regAddr_t rs2, input regAddr_t rs1,
                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encU(input int imm, input regAddr_t rd, input logic [6:0] opcode);
        return {imm[19:0], rd, opcode};
    endfunction

    function automatic word_t encJ(input int imm, input regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // rows sit at consecutive word addresses starting at 0x100
    function automatic word_t nextPc();
        return 32'h100 + 4 * rows.size();
    endfunction

    function automatic tableRow_t newRow(input word_t code);
        tableRow_t row;
        row = '0;
        row.instr = code;
        row.pc = nextPc();
        return row;
    endfunction

    task automatic pushRow(input string name, input tableRow_t row);
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    task automatic addAlu(input string name, input word_t code, input regAddr_t rd,
                          input word_t value);
        tableRow_t row;
        row = newRow(code);
        row.result = value;
        row.rd = rd;
        row.regWrite = (rd != '0);
        pushRow(name, row);
    endtask

    task automatic addLoad(input string name, input word_t code, input regAddr_t rd,
                           input word_t addr);
        tableRow_t row;
        row = newRow(code);
        row.result = addr;
        row.rd = rd;
        row.regWrite = 1'b1;
        row.memRead = 1'b1;
        pushRow(name, row);
    endtask

    task automatic addStore(input string name, input word_t code, input word_t addr,
                            input word_t data);
        tableRow_t row;
        row = newRow(code);
        row.result = addr;
        row.memWrite = 1'b1;
        row.storeData = data;
        row.checkStore = 1'b1;
        pushRow(name, row);
    endtask

    task automatic addBranch(input string name, input word_t code, input logic taken,
                             input word_t target);
        tableRow_t row;
        row = newRow(code);
        row.taken = taken;
        row.target = target;
        row.checkTarget = 1'b1;
        pushRow(name, row);
    endtask

    task automatic addJump(input string name, input word_t code, input regAddr_t rd,
                           input word_t target);
        tableRow_t row;
        row = newRow(code);
        row.result = row.pc + 4;
        row.rd = rd;
        row.regWrite = 1'b1;
        row.taken = 1'b1;
        row.target = target;
        row.checkTarget = 1'b1;
        pushRow(name, row);
    endtask

    // every output of a squashed instruction is zero
    task automatic addBubble(input string name, input word_t code, input logic flushLevel);
        tableRow_t row;
        row = newRow(code);
        row.flushIn = flushLevel;
        row.checkTarget = 1'b1;
        row.checkStore = 1'b1;
        pushRow(name, row);
    endtask

    task automatic writeBackWithLastRow(input regAddr_t rd, input word_t data);
        tableRow_t row;
        row = rows.pop_back();
        row.wbEn = 1'b1;
        row.wbRd = rd;
        row.wbData = data;
        rows.push_back(row);
    endtask

    task automatic buildTable();
        addAlu("add x9", encR(7'h00, 2, 1, 3'b000, 9), 9, 32'h0000_0013);
        addAlu("sub x10", encR(7'h20, 1, 2, 3'b000, 10), 10, 32'hFFFF_FFF3);
        addAlu("sra x11", encR(7'h20, 2, 3, 3'b101, 11), 11, 32'hFFFF_FFFE);
        addAlu("sltu x12", encR(7'h00, 3, 1, 3'b011, 12), 12, 32'h1);
        addAlu("slt x13", encR(7'h00, 1, 3, 3'b010, 13), 13, 32'h1);
        addAlu("xor x14", encR(7'h00, 8, 5, 3'b100, 14), 14, 32'h1234_5678 ^ 32'hDEAD_BEEF);
        addAlu("srai x15", encI(32'h404, 4, 3'b101, 15, 7'b0010011), 15, 32'hF800_0000);
        addAlu("addi x16", encI(-5, 3, 3'b000, 16, 7'b0010011), 16, 32'hFFFF_FFEB);
        addAlu("addi x0", encI(7, 1, 3'b000, 0, 7'b0010011), 0, 32'h0000_0017);
        addAlu("slli x17", encI(5, 2, 3'b001, 17, 7'b0010011), 17, 32'h0000_0060);
        addLoad("lw x18", encI(-8, 7, 3'b010, 18, 7'b0000011), 18, 32'h0000_0FF8);
        addStore("sw x8", encS(12, 8, 7, 3'b010), 32'h0000_100C, 32'hDEAD_BEEF);
        addBranch("beq taken", encB(16, 6, 1, 3'b000), 1'b1, nextPc() + 16);
        addBubble("after beq", encI(1, 1, 3'b000, 19, 7'b0010011), 1'b0);
        addBranch("bne not taken", encB(16, 6, 1, 3'b001), 1'b0, nextPc() + 16);
        addBranch("blt taken", encB(-8, 1, 3, 3'b100), 1'b1, nextPc() - 8);
        addBubble("after blt", encR(7'h00, 2, 1, 3'b000, 19), 1'b0);
        addBranch("bgeu taken", encB(32, 1, 3, 3'b111), 1'b1, nextPc() + 32);
        addBubble("after bgeu", encR(7'h00, 2, 1, 3'b000, 19), 1'b0);
        addBranch("bltu not taken", encB(8, 1, 3, 3'b110), 1'b0, nextPc() + 8);
        addJump("jal x20", encJ(64, 20), 20, nextPc() + 64);
        addBubble("after jal", encR(7'h00, 2, 1, 3'b000, 19), 1'b0);
        addJump("jalr x21", encI(5, 7, 3'b000, 21, 7'b1100111), 21, 32'h0000_1004);
        addBubble("after jalr", encR(7'h00, 2, 1, 3'b000, 19), 1'b0);
        addAlu("lui x22", encU(32'hABCDE, 22, 7'b0110111), 22, 32'hABCD_E000);
        addAlu("auipc x23", encU(32'h00012, 23, 7'b0010111), 23, nextPc() + 32'h0001_2000);
        addBubble("flushIn add", encR(7'h00, 2, 1, 3'b000, 24), 1'b1);
        // x2 is written back in the same cycle that add reads it
        addAlu("add bypass", encR(7'h00, 2, 1, 3'b000, 25), 25, 32'h0000_0110);
        writeBackWithLastRow(2, 32'h0000_0100);
        addAlu("sub new x2", encR(7'h20, 1, 2, 3'b000, 26), 26, 32'h0000_00F0);
    endtask

    task automatic checkValue(input string signal, input word_t got, input word_t expected);
        assert (got === expected)
        else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, signal, got, expected);
            rowErrors++;
        end
    endtask

    task automatic compareRow(input string name, input tableRow_t exp);
        rowErrors = 0;
        checkValue("result", result, exp.result);
        checkValue("exeRd", word_t'(exeRd), word_t'(exp.rd));
        checkValue("exeRegWrite", word_t'(exeRegWrite), word_t'(exp.regWrite));
        checkValue("exeMemWrite", word_t'(exeMemWrite), word_t'(exp.memWrite));
        checkValue("exeMemRead", word_t'(exeMemRead), word_t'(exp.memRead));
        checkValue("exeMemToReg", word_t'(exeMemToReg), word_t'(exp.memRead));
        checkValue("branchTaken", word_t'(branchTaken), word_t'(exp.taken));
        if (exp.checkTarget) begin
            checkValue("branchTarget", branchTarget, exp.target);
        end
        if (exp.checkStore) begin
            checkValue("storeData", storeData, exp.storeData);
        end
        checkedRows++;
        errorCount += rowErrors;
        if (rowErrors == 0) begin
            $display("%0t: %s ok", $time, name);
        end else begin
            failedRows++;
            $display("%0t: %s has %0d mismatches", $time, name, rowErrors);
        end
    endtask

    task automatic applyRow(input tableRow_t row);
        instr = row.instr;
        pc = row.pc;
        flushIn = row.flushIn;
        wbRegWrite = row.wbEn;
        wbRd = row.wbRd;
        wbData = row.wbData;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles before the table finished", cycleCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        tableRow_t idle;
        reset = 1'b1;
        instr = '0;
        pc = '0;
        flushIn = 1'b0;
        wbRegWrite = 1'b0;
        wbRd = '0;
        wbData = '0;
        buildTable();
        cycleLimit = 4 + 8 + rows.size() + 20;

        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
        idle = '0;
        idle.checkTarget = 1'b1;
        idle.checkStore = 1'b1;
        @(negedge clk);
        compareRow("after reset", idle);

        for (int i = 1; i <= 8; i++) begin
            @(posedge clk);
            #2;
            wbRegWrite = 1'b1;
            wbRd = regAddr_t'(i);
            wbData = preloadValue[i];
        end

        // each row is checked in the cycle after it is presented
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            #2;
            if (i < rows.size()) begin
                applyRow(rows[i]);
            end else begin
                applyRow(idle);
            end
            @(negedge clk);
            if (i > 0) begin
                compareRow(rowNames[i - 1], rows[i - 1]);
            end
        end

        $display("rows checked %0d, rows failed %0d, errors %0d, assertion failures %0d",
                 checkedRows, failedRows, errorCount, uut.checks.failures);
        if (errorCount == 0 && uut.checks.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeExecute.f ====
rtl/riscvPkg.sv
rtl/idExeIf.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/immediateGen.sv
rtl/idExeReg.sv
rtl/executeStage.sv
rtl/decodeExecute.sv
testbench/decodeExecute_assertions.sv
testbench/decodeExecuteTb.sv

// ==== Bender.yml ====
package:
  name: decodeExecute

sources:
  - files:
      - rtl/riscvPkg.sv
      - rtl/idExeIf.sv
      - rtl/controlDecoder.sv
      - rtl/registerFile.sv
      - rtl/immediateGen.sv
      - rtl/idExeReg.sv
      - rtl/executeStage.sv
      - rtl/decodeExecute.sv
  - target: test
    files:
      - testbench/decodeExecute_assertions.sv
      - testbench/decodeExecuteTb.sv
